// File: src/fermatPkg.sv
package fermatPkg;

	// modulus is 2^wordWidth+1, the fermat prime 65537
	localparam int wordWidth   = 16;
	localparam int prefixSpeed = 1;  // 0 serial, 1 brent-kung, 2 sklansky
	localparam int repeatWidth = 8;

	typedef logic [wordWidth-1:0]   dimOneT;  // value minus one, zero kept apart
	typedef logic [repeatWidth-1:0] repeatT;  // additions per operand write
	typedef logic [3:0]             axiAddrT; // byte offset in the register block
	typedef logic [31:0]            axiDataT;
	typedef logic [1:0]             axiRespT;

	// register map
	localparam axiAddrT regOperand = 4'h0; // write only, starts a burst
	localparam axiAddrT regRepeat  = 4'h4; // scale factor
	localparam axiAddrT regAcc     = 4'h8; // read accumulator, write clears

	localparam axiRespT axiOkay   = 2'b00;
	localparam axiRespT axiSlvErr = 2'b10;

	// data word holds the code in 15:0 and the zero flag in bit 16
	// remaining bits read back as 0

	typedef enum logic [1:0] {
		idle,      // waiting for a request
		accum,     // burst of modular additions running
		writeResp, // bvalid up
		readResp   // rvalid up
	} ctrlStateT;

endpackage

// File: src/prefixAndOr.sv
`timescale 1ns/1ps

module prefixAndOr #(
	parameter int width = 16, // bits in the tree
	parameter int speed = 1   // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] GI, // bit generate
	input  logic [width-1:0] PI, // bit propagate
	output logic [width-1:0] GO, // group generate i..0
	output logic [width-1:0] PO  // group propagate i..0
);

	localparam int m = $clog2(width); // log depth

	if (speed == 2) begin : sklansky
		// log depth, fanout doubles per level
		logic [width-1:0] gT [0:m];
		logic [width-1:0] pT [0:m];

		assign gT[0] = GI;
		assign pT[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : levels
			localparam int d = 2 ** (l - 1); // half group
			for (genvar i = 0; i < width; i++) begin : bits
				if ((i / d) % 2 == 1) begin : black
					localparam int j = i - (i % d) - 1; // msb of lower half
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][j]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][j];
				end else begin : white
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end
		assign GO = gT[m];
		assign PO = pT[m];
	end else if (speed == 1) begin : brentKung
		// up-sweep over m levels, then down-sweep fills the gaps
		logic [width-1:0] gT [0:2*m-1];
		logic [width-1:0] pT [0:2*m-1];

		assign gT[0] = GI;
		assign pT[0] = PI;
		for (genvar s = 1; s < 2 * m; s++) begin : stages
			localparam bit upSweep = (s <= m);
			localparam int d = upSweep ? 2 ** (s - 1) : 2 ** (2 * m - s - 1); // span
			for (genvar i = 0; i < width; i++) begin : bits
				localparam bit isBlack = upSweep ? ((i + 1) % (2 * d) == 0)
					: (((i + 1) % (2 * d) == d) && (i >= 2 * d));
				if (isBlack) begin : black
					assign gT[s][i] = gT[s-1][i] | (pT[s-1][i] & gT[s-1][i-d]);
					assign pT[s][i] = pT[s-1][i] & pT[s-1][i-d];
				end else begin : white
					assign gT[s][i] = gT[s-1][i];
					assign pT[s][i] = pT[s-1][i];
				end
			end
		end
		assign GO = gT[2*m-1];
		assign PO = pT[2*m-1];
	end else begin : serial
		// ripple chain, fewest nodes
		logic [width-1:0] gT;
		logic [width-1:0] pT;

		assign gT[0] = GI[0];
		assign pT[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : bits
			assign gT[i] = GI[i] | (PI[i] & gT[i-1]);
			assign pT[i] = PI[i] & pT[i-1];
		end
		assign GO = gT;
		assign PO = pT;
	end

endmodule

// File: src/addMod2Np1.sv
`timescale 1ns/1ps

module prefixAndOrCendaround #(
	parameter int width = 16,
	parameter int speed = 1
) (
	input  logic [width-1:0] GI,
	input  logic [width-1:0] PI,
	input  logic             CI, // end-around carry in
	output logic [width-1:0] GO,
	output logic [width-1:0] PO,
	output logic             CO  // carry out of the plain tree
);

	logic [width-1:0] gT; // tree outputs without carry in
	logic [width-1:0] pT;

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefixTree (
		.GI(GI),
		.PI(PI),
		.GO(gT),
		.PO(pT)
	);

	assign CO = gT[width-1];
	// one extra level folds the carry into every position
	assign GO = gT | (pT & {width{CI}});
	assign PO = pT;

endmodule

// S = A + B mod 2^width+1, all codes diminished-one
module addMod2Np1 #(
	parameter int width = 16,
	parameter int speed = 1
) (
	input  logic [width-1:0] A,
	input  logic [width-1:0] B,
	output logic [width-1:0] S
);

	logic [width-1:0] gI, pI; // bit generate/propagate
	logic [width-1:0] gO;     // carries with end-around folded in
	logic [width-1:0] halfSum;
	logic             cIn, cOut;

	assign gI      = A & B;
	assign pI      = A | B;
	assign halfSum = ~gI & pI; // a xor b

	prefixAndOrCendaround #(
		.width(width),
		.speed(speed)
	) eacPrefix (
		.GI(gI),
		.PI(pI),
		.CI(cIn),
		.GO(gO),
		.PO(),
		.CO(cOut)
	);

	assign cIn = ~cOut; // +1 when no overflow past 2^n
	assign S   = halfSum ^ {gO[width-2:0], cIn};

endmodule

// File: src/modAccumulator.sv
`timescale 1ns/1ps

module modAccumulator (
	input  logic              clk,
	input  logic              arstN,
	input  logic              stepEn,   // one addition this cycle
	input  logic              accClear, // wins over stepEn
	input  fermatPkg::dimOneT opCode,
	input  logic              opZero,
	output fermatPkg::dimOneT accCode,
	output logic              accZero
);
	import fermatPkg::*;

	dimOneT sum;       // adder result, valid when neither side is zero
	logic   sumIsZero; // a + b hits 2^n+1 exactly

	addMod2Np1 #(
		.width(wordWidth),
		.speed(prefixSpeed)
	) adder (
		.A(accCode),
		.B(opCode),
		.S(sum)
	);

	// codes add up to 2^n-1 only when the true values sum to the modulus
	assign sumIsZero = (opCode == ~accCode);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			accCode <= '0;
			accZero <= 1'b1;
		end else if (accClear) begin
			accCode <= '0;
			accZero <= 1'b1;
		end else if (stepEn && !opZero) begin // zero operand is a no-op
			if (accZero) begin
				accCode <= opCode; // 0 + x = x
				accZero <= 1'b0;
			end else if (sumIsZero) begin
				accCode <= '0;
				accZero <= 1'b1;
			end else begin
				accCode <= sum;
			end
		end
	end

endmodule

// File: src/repeatCounter.sv
`timescale 1ns/1ps

module repeatCounter (
	input  logic              clk,
	input  logic              arstN,
	input  logic              startRepeat, // load pulse
	input  fermatPkg::repeatT repeatCount,
	output logic              stepEn,
	output logic              lastStep,
	output logic              zeroCount    // load with count 0, same cycle
);
	import fermatPkg::*;

	repeatT remain;  // steps left including the current one
	logic   running;

	assign stepEn    = running;
	assign lastStep  = running && (remain == repeatT'(1));
	assign zeroCount = startRepeat && (repeatCount == '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
			remain  <= '0;
		end else if (startRepeat) begin
			running <= (repeatCount != '0); // steps start next cycle
			remain  <= repeatCount;
		end else if (running) begin
			remain  <= remain - repeatT'(1);
			running <= !lastStep;
		end
	end

endmodule

// File: src/axiLiteCtrlFsm.sv
`timescale 1ns/1ps

module axiLiteCtrlFsm (
	input  logic               clk,
	input  logic               arstN,
	input  fermatPkg::axiAddrT awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  fermatPkg::axiDataT wdata,
	input  logic               wvalid,
	output logic               wready,
	output fermatPkg::axiRespT bresp,
	output logic               bvalid,
	input  logic               bready,
	input  fermatPkg::axiAddrT araddr,
	input  logic               arvalid,
	output logic               arready,
	output fermatPkg::axiDataT rdata,
	output fermatPkg::axiRespT rresp,
	output logic               rvalid,
	input  logic               rready,
	output logic               startRepeat, // registered pulse after an OPERAND write
	output fermatPkg::repeatT  repeatCount, // the REPEAT register
	input  logic               lastStep,
	input  logic               zeroCount,
	output fermatPkg::dimOneT  opCode,      // latched operand
	output logic               opZero,
	output logic               accClear,
	input  fermatPkg::dimOneT  accCode,
	input  logic               accZero
);
	import fermatPkg::*;

	ctrlStateT state;
	logic      wrReq;  // aw and w both offered
	logic      wrFire; // write handshake
	logic      rdFire; // read handshake
	axiDataT   rdWord; // read mux

	function automatic logic isMapped(axiAddrT addr);
		return (addr == regOperand) || (addr == regRepeat) || (addr == regAcc);
	endfunction

	assign wrReq   = awvalid && wvalid;
	assign awready = (state == idle) && wrReq; // address and data in one go
	assign wready  = awready;
	assign arready = (state == idle) && !wrReq && arvalid; // write goes first
	assign wrFire  = awready;
	assign rdFire  = arready;
	assign bvalid  = (state == writeResp);
	assign rvalid  = (state == readResp);
	assign accClear = wrFire && (awaddr == regAcc); // any data clears

	always_comb begin
		case (araddr)
			regRepeat: rdWord = {{(32 - repeatWidth){1'b0}}, repeatCount};
			regAcc:    rdWord = {{(31 - wordWidth){1'b0}}, accZero, accCode};
			default:   rdWord = '0; // OPERAND is write only, unmapped reads 0
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state       <= idle;
			startRepeat <= 1'b0;
			repeatCount <= repeatT'(1);
		end else begin
			startRepeat <= 1'b0;
			case (state)
				idle: begin
					if (wrFire) begin
						if (awaddr == regOperand) begin
							state       <= accum;
							startRepeat <= 1'b1;
						end else begin
							state <= writeResp;
						end
						if (awaddr == regRepeat) begin
							repeatCount <= wdata[repeatWidth-1:0];
						end
					end else if (rdFire) begin
						state <= readResp;
					end
				end
				accum: begin
					if (lastStep || zeroCount) begin // burst done
						state <= writeResp;
					end
				end
				writeResp: begin
					if (bready) begin
						state <= idle;
					end
				end
				readResp: begin
					if (rready) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// payload, only looked at under valid or stepEn
	always_ff @(posedge clk) begin
		if (wrFire) begin
			bresp <= isMapped(awaddr) ? axiOkay : axiSlvErr;
			if (awaddr == regOperand) begin
				opCode <= wdata[wordWidth-1:0];
				opZero <= wdata[wordWidth]; // zero flag in bit 16
			end
		end
		if (rdFire) begin
			rdata <= rdWord; // held stable until rready
			rresp <= isMapped(araddr) ? axiOkay : axiSlvErr;
		end
	end

endmodule

// File: src/fermatAccTop.sv
`timescale 1ns/1ps

module fermatAccTop (
	input  logic               clk,
	input  logic               arstN,
	input  fermatPkg::axiAddrT awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  fermatPkg::axiDataT wdata,
	input  logic               wvalid,
	output logic               wready,
	output fermatPkg::axiRespT bresp,
	output logic               bvalid,
	input  logic               bready,
	input  fermatPkg::axiAddrT araddr,
	input  logic               arvalid,
	output logic               arready,
	output fermatPkg::axiDataT rdata,
	output fermatPkg::axiRespT rresp,
	output logic               rvalid,
	input  logic               rready
);
	import fermatPkg::*;

	logic   startRepeat;
	repeatT repeatCount;
	logic   stepEn, lastStep, zeroCount; // counter to fsm and accumulator
	dimOneT opCode;
	logic   opZero;
	logic   accClear;
	dimOneT accCode;  // read back through ACC
	logic   accZero;

	axiLiteCtrlFsm ctrlFsm (
		.clk        (clk),
		.arstN      (arstN),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.startRepeat(startRepeat),
		.repeatCount(repeatCount),
		.lastStep   (lastStep),
		.zeroCount  (zeroCount),
		.opCode     (opCode),
		.opZero     (opZero),
		.accClear   (accClear),
		.accCode    (accCode),
		.accZero    (accZero)
	);

	repeatCounter repCnt (
		.clk        (clk),
		.arstN      (arstN),
		.startRepeat(startRepeat),
		.repeatCount(repeatCount),
		.stepEn     (stepEn),
		.lastStep   (lastStep),
		.zeroCount  (zeroCount)
	);

	modAccumulator accReg (
		.clk     (clk),
		.arstN   (arstN),
		.stepEn  (stepEn),
		.accClear(accClear),
		.opCode  (opCode),
		.opZero  (opZero),
		.accCode (accCode),
		.accZero (accZero)
	);

endmodule

// File: dv/tbClkRst.sv
`timescale 1ns/1ps

module tbClkRst #(
	parameter int period      = 100, // ns
	parameter int resetCycles = 3
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// reset low from time 0, released on a rising edge
	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

// File: dv/fermatAccTb.sv
`timescale 1ns/1ps

module fermatAccTb;
	import fermatPkg::*;

	localparam int clkPeriod   = 100;
	localparam int modulus     = (1 << wordWidth) + 1; // 65537
	localparam int randAdds    = 200;
	localparam int repSweeps   = 40;
	localparam int errSweeps   = 10;
	localparam int stallSweeps = 10;
	localparam int numOps      = 2 + 2 * randAdds + 4 * repSweeps + 4 * errSweeps
		+ 5 * stallSweeps + 40;           // bus operations, rough upper bound
	localparam int cyclesPerOp = 255 + 10; // longest burst plus handshakes
	localparam axiAddrT stallAddr = 4'hC;  // queued during back-pressure

	logic    clk, arstN;
	axiAddrT awaddr, araddr;
	axiDataT wdata, rdata;
	axiRespT bresp, rresp;
	logic    awvalid, awready, wvalid, wready, bvalid, bready;
	logic    arvalid, arready, rvalid, rready;

	integer seed = 42;
	int     accModel;    // true value 0..65536
	int     repeatModel; // REPEAT as software sees it

	tbClkRst #(.period(clkPeriod), .resetCycles(3)) clkGen (.clk(clk), .arstN(arstN));

	fermatAccTop i_fermatAccTop (
		.clk(clk), .arstN(arstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	task automatic failRun();
		$display("STATUS: FAIL");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic checkData(input string name, input axiDataT expected, input axiDataT actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			failRun();
		end
	endtask

	task automatic checkResp(input string name, input axiRespT expected, input axiRespT actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected resp %b, actual resp %b", name, expected, actual);
			failRun();
		end
	endtask

	task automatic checkLatency(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("[ERROR] %s: expected %0d wait cycles, actual %0d", name, expected, actual);
			failRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
			failRun();
		end
	endtask

	// value 0 is the zero flag alone, otherwise the code is value-1
	function automatic axiDataT modelWord(input int value);
		return (value == 0) ? 32'h0001_0000 : axiDataT'(value - 1);
	endfunction

	function automatic int operandValue(input axiDataT word);
		return word[16] ? 0 : int'(word[15:0]) + 1;
	endfunction

	function automatic axiAddrT randUnmapped();
		axiAddrT addr;
		addr = axiAddrT'($random(seed));
		while (addr == regOperand || addr == regRepeat || addr == regAcc) begin
			addr = axiAddrT'($random(seed));
		end
		return addr;
	endfunction

	// response held back for hold cycles while a write waits behind it
	task automatic stallResponse(input string name, input bit isRead, input int hold,
			input axiDataT data, input axiRespT resp);
		awaddr  <= stallAddr;
		wdata   <= axiDataT'($random(seed));
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		for (int i = 0; i <= hold; i++) begin
			if (i == hold && isRead) begin
				rready <= 1'b1;
			end else if (i == hold) begin
				bready <= 1'b1;
			end
			@(posedge clk);
			checkFlag({name, " valid held"}, 1'b1, isRead ? rvalid : bvalid);
			checkFlag({name, " awready held low"}, 1'b0, awready);
			checkFlag({name, " wready held low"}, 1'b0, wready);
			checkResp({name, " resp stable"}, resp, isRead ? rresp : bresp);
			if (isRead) begin
				checkData({name, " rdata stable"}, data, rdata);
			end
		end
		@(posedge clk); // queued write goes in once idle
		while (!awready) begin
			@(posedge clk);
		end
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		bready  <= 1'b1;
		@(posedge clk);
		while (!bvalid) begin
			@(posedge clk);
		end
		checkResp({name, " queued write"}, axiSlvErr, bresp);
	endtask

	// lat counts the cycles between handshake and response
	task automatic writeReg(input string name, input axiAddrT addr, input axiDataT data,
			input int hold, output axiRespT resp, output int lat);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		bready  <= (hold == 0);
		@(posedge clk);
		while (!awready) begin
			@(posedge clk);
		end
		checkFlag({name, " wready"}, 1'b1, wready); // data taken with the address
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		lat = 0;
		@(posedge clk);
		while (!bvalid) begin
			lat++;
			@(posedge clk);
		end
		resp = bresp;
		if (hold > 0) begin
			stallResponse(name, 1'b0, hold, '0, resp);
		end
	endtask

	task automatic readReg(input string name, input axiAddrT addr, input int hold,
			output axiDataT data, output axiRespT resp);
		int lat;
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= (hold == 0);
		@(posedge clk);
		while (!arready) begin
			@(posedge clk);
		end
		arvalid <= 1'b0;
		lat = 0;
		@(posedge clk);
		while (!rvalid) begin
			lat++;
			@(posedge clk);
		end
		data = rdata;
		resp = rresp;
		checkLatency({name, " read"}, 0, lat);
		if (hold > 0) begin
			stallResponse(name, 1'b1, hold, data, resp);
		end
	endtask

	task automatic setRepeat(input string name, input int count);
		axiDataT data;
		axiRespT resp;
		int      lat;
		data = axiDataT'($random(seed)); // upper bits are don't care
		data[repeatWidth-1:0] = repeatT'(count);
		writeReg(name, regRepeat, data, 0, resp, lat);
		checkResp(name, axiOkay, resp);
		checkLatency(name, 0, lat);
		repeatModel = count;
	endtask

	task automatic clearAcc(input string name);
		axiRespT resp;
		int      lat;
		writeReg(name, regAcc, axiDataT'($random(seed)), 0, resp, lat);
		checkResp(name, axiOkay, resp);
		checkLatency(name, 0, lat);
		accModel = 0;
	endtask

	task automatic addOperand(input string name, input axiDataT word, input int hold);
		axiRespT resp;
		int      lat;
		writeReg(name, regOperand, word, hold, resp, lat);
		checkResp(name, axiOkay, resp);
		checkLatency(name, repeatModel + 1, lat); // one addition per cycle
		accModel = (accModel + repeatModel * operandValue(word)) % modulus;
	endtask

	task automatic expectAcc(input string name, input int hold);
		axiDataT data;
		axiRespT resp;
		readReg(name, regAcc, hold, data, resp);
		checkData(name, modelWord(accModel), data);
		checkResp(name, axiOkay, resp);
	endtask

	task automatic expectRepeat(input string name);
		axiDataT data;
		axiRespT resp;
		readReg(name, regRepeat, 0, data, resp);
		checkData(name, axiDataT'(repeatModel), data);
		checkResp(name, axiOkay, resp);
	endtask

	initial begin
		#(numOps * cyclesPerOp * clkPeriod);
		$display("run timed out, the DUT stopped answering on the bus");
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		axiDataT data;
		axiRespT resp;
		axiAddrT addr;
		int      lat;
		awaddr      = '0;
		awvalid     = 1'b0;
		wdata       = '0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		araddr      = '0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		accModel    = 0;
		repeatModel = 1;
		@(posedge clk);
		while (!arstN) begin
			@(posedge clk);
		end

		expectAcc("reset ACC", 0); // zero flag, code 0
		expectRepeat("reset REPEAT");

		setRepeat("single add", 1);
		for (int i = 0; i < randAdds; i++) begin
			addOperand("single add", axiDataT'(16'($random(seed))), 0);
			expectAcc("single add", 0);
		end

		for (int i = 0; i < repSweeps; i++) begin
			setRepeat("repeat sweep", $unsigned($random(seed)) % 21);
			addOperand("repeat sweep", axiDataT'(16'($random(seed))), 0);
			expectAcc("repeat sweep", 0);
			expectRepeat("repeat sweep");
		end

		// zero corners
		clearAcc("zero handling");
		setRepeat("zero handling", 1);
		addOperand("zero operand on zero acc", 32'h0001_0000 | 16'($random(seed)), 0);
		expectAcc("zero operand on zero acc", 0);
		addOperand("load into zero acc", axiDataT'(16'($random(seed))), 0);
		expectAcc("load into zero acc", 0);
		setRepeat("zero handling", 3);
		addOperand("zero operand", 32'h0001_0000, 0);
		expectAcc("zero operand", 0);
		setRepeat("zero handling", 1);
		data = modelWord(accModel);
		addOperand("complement", axiDataT'(~data[15:0]), 0); // values sum to the modulus
		readReg("complement", regAcc, 0, data, resp);
		checkData("complement", 32'h0001_0000, data);
		checkResp("complement", axiOkay, resp);

		clearAcc("clear");
		expectAcc("clear", 0);
		setRepeat("after clear", 2);
		addOperand("after clear", axiDataT'(16'($random(seed))), 0);
		expectAcc("after clear", 0);

		for (int i = 0; i < errSweeps; i++) begin
			addr = randUnmapped();
			writeReg("unmapped write", addr, axiDataT'($random(seed)), 0, resp, lat);
			checkResp("unmapped write", axiSlvErr, resp);
			checkLatency("unmapped write", 0, lat);
			readReg("unmapped read", addr, 0, data, resp);
			checkData("unmapped read", '0, data);
			checkResp("unmapped read", axiSlvErr, resp);
			expectAcc("unmapped no effect", 0);
			expectRepeat("unmapped no effect");
		end

		for (int i = 0; i < stallSweeps; i++) begin
			setRepeat("back-pressure", $unsigned($random(seed)) % 6);
			addOperand("bready stall", axiDataT'(16'($random(seed))),
				1 + $unsigned($random(seed)) % 8);
			expectAcc("rready stall", 1 + $unsigned($random(seed)) % 8);
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: filelist.f
src/fermatPkg.sv
src/prefixAndOr.sv
src/addMod2Np1.sv
src/modAccumulator.sv
src/repeatCounter.sv
src/axiLiteCtrlFsm.sv
src/fermatAccTop.sv
dv/tbClkRst.sv
dv/fermatAccTb.sv

// File: Bender.yml
package:
  name: fermat_acc

sources:
  - files:
      - src/fermatPkg.sv
      - src/prefixAndOr.sv
      - src/addMod2Np1.sv
      - src/modAccumulator.sv
      - src/repeatCounter.sv
      - src/axiLiteCtrlFsm.sv
      - src/fermatAccTop.sv
  - target: simulation
    files:
      - dv/tbClkRst.sv
      - dv/fermatAccTb.sv
